// File: source/vna_sample_pkg.sv
package vna_sample_pkg;

    // Component width, also the width of magnitude and phase fields
    localparam int sample_w = 16;

    // Complex baseband sample as delivered by a receiver channel
    typedef struct packed {
        logic signed [sample_w-1:0] i;
        logic signed [sample_w-1:0] q;
    } iq_t;

    // Phase is a binary angle, a full turn is 2^16
    typedef struct packed {
        logic [sample_w-1:0] mag;
        logic [sample_w-1:0] phase;
    } polar_t;

    // One channel word, read as I/Q before the CORDIC and as polar after it
    typedef union packed {
        iq_t    iq;
        polar_t polar;
    } chan_word_u;

    // Port 1 forward/reverse and port 2 forward/reverse
    typedef struct packed {
        chan_word_u a1;
        chan_word_u b1;
        chan_word_u a2;
        chan_word_u b2;
    } chan_set_t;

endpackage

// File: source/vna_sweep_pkg.sv
package vna_sweep_pkg;

    // Width of the sweep length exponent
    localparam int log2_w = 4;

    // Sweep phases
    typedef enum logic [1:0] {
        idle,
        accum,
        finish
    } sweep_state_e;

endpackage

// File: source/cordic_vectoring.sv
`timescale 1ns/1ns

module cordic_vectoring import vna_sample_pkg::*; #(
    parameter int CORDIC_STAGES = 12
) (
    input  logic       aclk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  chan_word_u in_word,
    output logic       out_valid,
    output chan_word_u out_word
);

    localparam int guard_w = 4;
    localparam int xy_w = sample_w + 2 + guard_w;   // Room for pre-rotation and CORDIC gain
    localparam int ang_w = sample_w + 4;

    // atan(2^-k) in binary angle units, 2^20 per turn
    function automatic logic [ang_w-1:0] atan_tab(input int k);
        case (k)
            0:  atan_tab = ang_w'(131072);
            1:  atan_tab = ang_w'(77376);
            2:  atan_tab = ang_w'(40884);
            3:  atan_tab = ang_w'(20753);
            4:  atan_tab = ang_w'(10417);
            5:  atan_tab = ang_w'(5213);
            6:  atan_tab = ang_w'(2607);
            7:  atan_tab = ang_w'(1304);
            8:  atan_tab = ang_w'(652);
            9:  atan_tab = ang_w'(326);
            10: atan_tab = ang_w'(163);
            11: atan_tab = ang_w'(81);
            12: atan_tab = ang_w'(41);
            13: atan_tab = ang_w'(20);
            14: atan_tab = ang_w'(10);
            15: atan_tab = ang_w'(5);
            default: atan_tab = ang_w'(166886 >> k);  // Small angle, atan(x) ~ x
        endcase
    endfunction

    logic signed [xy_w-1:0] x_q [CORDIC_STAGES+1];
    logic signed [xy_w-1:0] y_q [CORDIC_STAGES+1];
    logic [ang_w-1:0] z_q [CORDIC_STAGES+1];
    logic [CORDIC_STAGES:0] v_q;
    logic signed [xy_w-1:0] i_ext;
    logic signed [xy_w-1:0] q_ext;
    logic signed [xy_w-1:0] mag_full;
    logic [ang_w-1:0] ph_full;

    assign i_ext = xy_w'(in_word.iq.i) <<< guard_w;
    assign q_ext = xy_w'(in_word.iq.q) <<< guard_w;

    // Fold the left half-plane onto the right one
    always_ff @(posedge aclk) begin
        if (in_word.iq.i[sample_w-1]) begin
            if (!in_word.iq.q[sample_w-1]) begin
                x_q[0] <= q_ext;
                y_q[0] <= -i_ext;
                z_q[0] <= ang_w'(1) << (ang_w - 2);    // +90 deg
            end else begin
                x_q[0] <= -q_ext;
                y_q[0] <= i_ext;
                z_q[0] <= ang_w'(3) << (ang_w - 2);    // -90 deg
            end
        end else begin
            x_q[0] <= i_ext;
            y_q[0] <= q_ext;
            z_q[0] <= '0;
        end
    end

    for (genvar k = 0; k < CORDIC_STAGES; k++) begin : g_stage
        always_ff @(posedge aclk) begin
            if (y_q[k][xy_w-1]) begin  // Below the axis, rotate up
                x_q[k+1] <= x_q[k] - (y_q[k] >>> k);
                y_q[k+1] <= y_q[k] + (x_q[k] >>> k);
                z_q[k+1] <= z_q[k] - atan_tab(k);
            end else begin
                x_q[k+1] <= x_q[k] + (y_q[k] >>> k);
                y_q[k+1] <= y_q[k] - (x_q[k] >>> k);
                z_q[k+1] <= z_q[k] + atan_tab(k);
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            v_q <= '0;
        end else begin
            v_q <= {v_q[CORDIC_STAGES-1:0], in_valid};
        end
    end

    // Round off guard bits, gain stays in the magnitude
    assign mag_full = (x_q[CORDIC_STAGES] + xy_w'(1 << (guard_w - 1))) >>> guard_w;
    assign ph_full = z_q[CORDIC_STAGES] + ang_w'(1 << (ang_w - sample_w - 1));

    always_comb begin
        if (mag_full > xy_w'(2 ** sample_w - 1)) begin
            out_word.polar.mag = '1;
        end else begin
            out_word.polar.mag = mag_full[sample_w-1:0];
        end
        out_word.polar.phase = ph_full[ang_w-1 -: sample_w];
    end

    assign out_valid = v_q[CORDIC_STAGES];

    a_valid_latency: assert property (@(posedge aclk) disable iff (!rst_n)
        out_valid == $past(in_valid && rst_n, CORDIC_STAGES + 1))
        else $error("CORDIC output valid does not follow input valid");

endmodule

// File: source/sample_counter.sv
`timescale 1ns/1ns

module sample_counter import vna_sweep_pkg::*; #(
    parameter int MAX_LOG2_SAMPLES = 12
) (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              sweep_clear,
    input  logic              take,
    input  logic [log2_w-1:0] num_samples_log2,
    output logic              final_take,
    output logic [log2_w-1:0] active_log2
);

    logic [MAX_LOG2_SAMPLES:0] count;
    logic [MAX_LOG2_SAMPLES:0] target;

    assign target = {{MAX_LOG2_SAMPLES{1'b0}}, 1'b1} << active_log2;
    assign final_take = take && ((count + 1'b1) == target);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            active_log2 <= '0;
        end else if (sweep_clear) begin
            count <= '0;
            if (num_samples_log2 > log2_w'(MAX_LOG2_SAMPLES)) begin
                active_log2 <= log2_w'(MAX_LOG2_SAMPLES);   // Clamp to accumulator range
            end else begin
                active_log2 <= num_samples_log2;
            end
        end else if (take) begin
            count <= count + 1'b1;
        end
    end

    a_count_range: assert property (@(posedge aclk) disable iff (!rst_n)
        count <= target)
        else $error("Sample count ran past the sweep length");

endmodule

// File: source/sweep_fsm.sv
`timescale 1ns/1ns

module sweep_fsm import vna_sweep_pkg::*; (
    input  logic aclk,
    input  logic rst_n,
    input  logic start,
    input  logic polar_valid,
    input  logic final_take,
    output logic sweep_clear,
    output logic take,
    output logic finish,
    output logic busy,
    output logic done
);

    sweep_state_e state;

    // The finish port hides the state name, so that one is scoped
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= accum;
                    end
                end
                accum: begin
                    if (take && final_take) begin
                        state <= vna_sweep_pkg::finish;
                    end
                end
                default: state <= idle;   // Finish lasts one cycle
            endcase
        end
    end

    assign sweep_clear = (state == idle) && start;
    assign take = (state == accum) && polar_valid;
    assign finish = (state == vna_sweep_pkg::finish);
    assign busy = (state != idle);
    assign done = finish;

    a_done_pulse: assert property (@(posedge aclk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held for more than one cycle");

    // A take is followed by at least one more busy cycle
    a_take_busy: assert property (@(posedge aclk) disable iff (!rst_n)
        take |-> busy ##1 busy)
        else $error("Sample taken outside a sweep");

endmodule

// File: source/phase_mag_averager.sv
`timescale 1ns/1ns

module phase_mag_averager import vna_sample_pkg::*; import vna_sweep_pkg::*; #(
    parameter int MAX_LOG2_SAMPLES = 12
) (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              sweep_clear,
    input  logic              take,
    input  logic              finish,
    input  logic [log2_w-1:0] active_log2,
    input  chan_set_t         polar_in,
    output chan_set_t         results
);

    localparam int acc_w = sample_w + MAX_LOG2_SAMPLES;

    chan_word_u chan [4];
    chan_word_u mean [4];
    logic signed [sample_w-1:0] rel_ph [4];
    logic [acc_w-1:0] mag_sum [4];
    logic signed [acc_w-1:0] ph_sum [4];

    assign chan[0] = polar_in.a1;
    assign chan[1] = polar_in.b1;
    assign chan[2] = polar_in.a2;
    assign chan[3] = polar_in.b2;

    // Phase relative to a1, wraps into +-180 deg
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            rel_ph[c] = chan[c].polar.phase - chan[0].polar.phase;
        end
    end

    always_ff @(posedge aclk) begin
        for (int c = 0; c < 4; c++) begin
            if (sweep_clear) begin
                mag_sum[c] <= '0;
                ph_sum[c] <= '0;
            end else if (take) begin
                mag_sum[c] <= mag_sum[c] + acc_w'(chan[c].polar.mag);
                ph_sum[c] <= ph_sum[c] + acc_w'(rel_ph[c]);
            end
        end
    end

    // Sweep length is a power of two, so the mean is a shift
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            mean[c].polar.mag = sample_w'(mag_sum[c] >> active_log2);
            mean[c].polar.phase = sample_w'(ph_sum[c] >>> active_log2);
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            results <= '0;
        end else if (sweep_clear) begin
            results <= '0;
        end else if (finish) begin
            results <= '{a1: mean[0], b1: mean[1], a2: mean[2], b2: mean[3]};
        end
    end

endmodule

// File: source/vna_dsp_top.sv
`timescale 1ns/1ns

module vna_dsp_top import vna_sample_pkg::*; import vna_sweep_pkg::*; #(
    parameter int CORDIC_STAGES = 12,
    parameter int MAX_LOG2_SAMPLES = 12
) (
    input  logic              aclk,
    input  logic              rst_n,
    input  chan_set_t         samples,
    input  logic              sample_valid,
    input  logic [log2_w-1:0] num_samples_log2,
    input  logic              start,
    output logic              busy,
    output logic              done,
    output chan_set_t         results
);

    chan_set_t polar_set;
    logic polar_valid;          // All four CORDICs share one latency
    logic sweep_clear;
    logic take;
    logic finish;
    logic final_take;
    logic [log2_w-1:0] active_log2;

    cordic_vectoring #(.CORDIC_STAGES(CORDIC_STAGES)) u_cordic_a1 (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (sample_valid),
        .in_word   (samples.a1),
        .out_valid (polar_valid),
        .out_word  (polar_set.a1)
    );

    cordic_vectoring #(.CORDIC_STAGES(CORDIC_STAGES)) u_cordic_b1 (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (sample_valid),
        .in_word   (samples.b1),
        .out_valid (),
        .out_word  (polar_set.b1)
    );

    cordic_vectoring #(.CORDIC_STAGES(CORDIC_STAGES)) u_cordic_a2 (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (sample_valid),
        .in_word   (samples.a2),
        .out_valid (),
        .out_word  (polar_set.a2)
    );

    cordic_vectoring #(.CORDIC_STAGES(CORDIC_STAGES)) u_cordic_b2 (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (sample_valid),
        .in_word   (samples.b2),
        .out_valid (),
        .out_word  (polar_set.b2)
    );

    sweep_fsm u_sweep_fsm (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .start       (start),
        .polar_valid (polar_valid),
        .final_take  (final_take),
        .sweep_clear (sweep_clear),
        .take        (take),
        .finish      (finish),
        .busy        (busy),
        .done        (done)
    );

    sample_counter #(.MAX_LOG2_SAMPLES(MAX_LOG2_SAMPLES)) u_sample_counter (
        .aclk             (aclk),
        .rst_n            (rst_n),
        .sweep_clear      (sweep_clear),
        .take             (take),
        .num_samples_log2 (num_samples_log2),
        .final_take       (final_take),
        .active_log2      (active_log2)
    );

    phase_mag_averager #(.MAX_LOG2_SAMPLES(MAX_LOG2_SAMPLES)) u_phase_mag_averager (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .sweep_clear (sweep_clear),
        .take        (take),
        .finish      (finish),
        .active_log2 (active_log2),
        .polar_in    (polar_set),
        .results     (results)
    );

endmodule

// File: verif/tb_vna_dsp_top.sv
`timescale 1ns/1ns

module tb_vna_dsp_top
    import vna_sample_pkg::*;
    import vna_sweep_pkg::*;
();

    localparam real pi = 3.14159265358979;
    localparam int sweep_total = 4 + 8 + 4 + 4096;      // Samples over all sweeps
    localparam int watchdog_cycles = sweep_total * 4 + 500;

    logic aclk;
    logic rst_n;
    chan_set_t samples;
    logic sample_valid;
    logic [log2_w-1:0] num_samples_log2;
    logic start;
    logic busy;
    logic done;
    chan_set_t results;

    integer seed = 32'h2993_578a;
    int errors = 0;
    int done_count = 0;
    int done_base = 0;
    real amp [4];
    real deg [4];
    real mag_acc [4];       // Model sums over the sweep's own samples
    real ph_acc [4];
    string chan_name [4] = '{"a1", "b1", "a2", "b2"};

    vna_dsp_top u_vna_dsp_top (
        .aclk             (aclk),
        .rst_n            (rst_n),
        .samples          (samples),
        .sample_valid     (sample_valid),
        .num_samples_log2 (num_samples_log2),
        .start            (start),
        .busy             (busy),
        .done             (done),
        .results          (results)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge aclk);
        $display("Watchdog expired before the sweeps finished, errors so far %0d", errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic note_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    a_done_single: assert property (@(posedge aclk) disable iff (!rst_n) done |=> !done)
        else note_failure("done stayed high for more than one cycle");

    a_busy_drop: assert property (@(posedge aclk) disable iff (!rst_n) done |=> !busy)
        else note_failure("busy did not fall in the cycle after done");

    a_zero_before_done: assert property (@(posedge aclk) disable iff (!rst_n)
        (done_count == 0) |-> (results == '0))
        else note_failure("results changed before the first done");

    function automatic chan_word_u chan_of(input chan_set_t s, input int c);
        case (c)
            0: chan_of = s.a1;
            1: chan_of = s.b1;
            2: chan_of = s.a2;
            default: chan_of = s.b2;
        endcase
    endfunction

    // Sets amp and deg for one sample of the given pattern
    task automatic pick_vector(input int kind, input int idx);
        case (kind)
            2: begin
                amp = '{18000.0, 18000.0, 18000.0, 18000.0};
                deg = '{0.0, 120.0, -120.0, 45.0};
            end
            3: begin
                deg[0] = real'($random(seed) % 180);
                for (int c = 0; c < 4; c++) begin
                    amp[c] = 1000.0 + real'($random(seed) & 32'h3fff);
                    if (c > 0) begin
                        deg[c] = deg[0] + real'($random(seed) % 140);   // Keeps |diff| < 150
                    end
                end
            end
            default: begin
                amp = '{8000.0, 3000.0, 12000.0, 5000.0};
                deg = '{30.0, -60.0, 100.0, 170.0};
                if (kind == 1) begin
                    amp[1] = (idx % 2 == 0) ? 2000.0 : 9000.0;
                end
            end
        endcase
    endtask

    // Starts and ends on a falling edge
    task automatic drive_sample(input bit counted);
        iq_t v [4];
        int ii;
        int qq;
        real ang [4];
        real rel;
        for (int c = 0; c < 4; c++) begin
            ii = $rtoi(amp[c] * $cos(deg[c] * pi / 180.0));
            qq = $rtoi(amp[c] * $sin(deg[c] * pi / 180.0));
            v[c].i = sample_w'(ii);
            v[c].q = sample_w'(qq);
            ang[c] = $atan2(real'(qq), real'(ii)) * 65536.0 / (2.0 * pi);
            rel = ang[c] - ang[0];
            if (rel > 32768.0) begin
                rel -= 65536.0;
            end else if (rel < -32768.0) begin
                rel += 65536.0;
            end
            if (counted) begin
                mag_acc[c] += 1.6468 * $sqrt(real'(ii * ii + qq * qq));
                ph_acc[c] += rel;
            end
        end
        samples.a1.iq = v[0];
        samples.b1.iq = v[1];
        samples.a2.iq = v[2];
        samples.b2.iq = v[3];
        sample_valid = 1'b1;
        if (counted) begin
            assert (busy && done_count == done_base)
            else note_failure("sweep ended before all of its samples were sent");
        end
        @(negedge aclk);
        sample_valid = 1'b0;
        start = 1'b0;
        if (($random(seed) & 3) == 0) begin
            @(negedge aclk);    // Random gap
        end
    endtask

    task automatic check_near(input string test, input string what, input real expected,
                              input int actual, input real tol);
        real diff;
        diff = real'(actual) - expected;
        assert (diff <= tol && diff >= -tol)
        else begin
            errors++;
            $display("[FAIL] %s %s: expected %0.1f, actual %0d", test, what, expected, actual);
        end
    endtask

    task automatic check_results(input string test, input int n);
        chan_word_u w;
        real e_mag;
        for (int c = 0; c < 4; c++) begin
            w = chan_of(results, c);
            e_mag = mag_acc[c] / n;
            check_near(test, {chan_name[c], " magnitude"}, e_mag, int'(w.polar.mag),
                       4.0 + 0.003 * e_mag);
            check_near(test, {chan_name[c], " phase"}, ph_acc[c] / n,
                       int'($signed(w.polar.phase)), (c == 0) ? 0.0 : 16.0);
        end
    endtask

    task automatic run_sweep(input string test, input int kind, input int log2_req,
                             input int n, input bit idle_junk, input bit restart);
        for (int c = 0; c < 4; c++) begin
            mag_acc[c] = 0.0;
            ph_acc[c] = 0.0;
        end
        if (idle_junk) begin
            for (int k = 0; k < 6; k++) begin
                pick_vector(2, k);
                drive_sample(1'b0);
            end
        end
        repeat (20) @(negedge aclk);    // Lets the CORDIC pipeline drain
        num_samples_log2 = log2_w'(log2_req);
        start = 1'b1;
        @(negedge aclk);
        start = 1'b0;
        num_samples_log2 = '0;
        done_base = done_count;
        for (int k = 0; k < n; k++) begin
            if (restart && k == n / 2) begin
                start = 1'b1;
                num_samples_log2 = log2_w'(1);
            end
            pick_vector(kind, k);
            drive_sample(1'b1);
            num_samples_log2 = '0;
        end
        while (!done) begin
            @(negedge aclk);
        end
        @(negedge aclk);
        check_results(test, n);
        repeat (30) @(negedge aclk);
        assert (done_count == done_base + 1)
        else begin
            errors++;
            $display("[FAIL] %s done pulses: expected 1, actual %0d", test,
                     done_count - done_base);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        samples = '0;
        sample_valid = 1'b0;
        num_samples_log2 = '0;
        start = 1'b0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        assert (!busy && !done && results == '0)
        else begin
            errors++;
            $display("[FAIL] after_reset busy done results: expected 0 0 0, actual %0b %0b %0h",
                     busy, done, results);
        end
        run_sweep("const_log2_2", 0, 2, 4, 1'b0, 1'b0);
        run_sweep("alt_b1_log2_3", 1, 3, 8, 1'b0, 1'b0);
        run_sweep("idle_and_restart", 3, 2, 4, 1'b1, 1'b1);
        run_sweep("clamp_log2_15", 3, 15, 4096, 1'b0, 1'b0);
        $display("Summary: %0d errors, %0d done pulses", errors, done_count);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
source/vna_sample_pkg.sv
source/vna_sweep_pkg.sv
source/cordic_vectoring.sv
source/sample_counter.sv
source/sweep_fsm.sv
source/phase_mag_averager.sv
source/vna_dsp_top.sv
verif/tb_vna_dsp_top.sv

// File: Makefile
TOP := tb_vna_dsp_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module vna_dsp_top -f flist.f

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f flist.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
